//--- design/rv_isa_pkg.sv
// rv64im isa encoding: opcodes, decoded field types and control codes
package rv_isa_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;
  typedef logic [4:0]  alu_op_t;
  typedef logic [2:0]  branch_t;
  typedef logic [2:0]  mem_op_t;
  typedef logic [1:0]  b_src_t;

  // major opcodes
  localparam opcode_t OP_LUI     = 7'b0110111;
  localparam opcode_t OP_AUIPC   = 7'b0010111;
  localparam opcode_t OP_JAL     = 7'b1101111;
  localparam opcode_t OP_JALR    = 7'b1100111;
  localparam opcode_t OP_BRANCH  = 7'b1100011;
  localparam opcode_t OP_LOAD    = 7'b0000011;
  localparam opcode_t OP_STORE   = 7'b0100011;
  localparam opcode_t OP_IMM     = 7'b0010011;
  localparam opcode_t OP_IMM_32  = 7'b0011011;
  localparam opcode_t OP_REG     = 7'b0110011;
  localparam opcode_t OP_REG_32  = 7'b0111011;
  localparam opcode_t OP_SYSTEM  = 7'b1110011;

  localparam funct7_t F7_BASE    = 7'b0000000;
  localparam funct7_t F7_ALT     = 7'b0100000; // sub, sra
  localparam funct7_t F7_MULDIV  = 7'b0000001;

  localparam alu_op_t ALU_ADD      = 5'd0;
  localparam alu_op_t ALU_SUB      = 5'd1;
  localparam alu_op_t ALU_SLT      = 5'd2;
  localparam alu_op_t ALU_SLTU     = 5'd3;
  localparam alu_op_t ALU_XOR      = 5'd4;
  localparam alu_op_t ALU_AND      = 5'd5;
  localparam alu_op_t ALU_OR       = 5'd6;
  localparam alu_op_t ALU_SLL      = 5'd7;
  localparam alu_op_t ALU_SRL      = 5'd8;
  localparam alu_op_t ALU_SRA      = 5'd9;
  localparam alu_op_t ALU_MUL      = 5'd10;
  localparam alu_op_t ALU_DIV      = 5'd11;
  localparam alu_op_t ALU_DIVU     = 5'd12;
  localparam alu_op_t ALU_REM      = 5'd13;
  localparam alu_op_t ALU_REMU     = 5'd14;
  localparam alu_op_t ALU_COPY_IMM = 5'd15;
  localparam alu_op_t ALU_EBREAK   = 5'd30;
  localparam alu_op_t ALU_INVALID  = 5'd31;

  localparam branch_t BR_NONE = 3'd0;
  localparam branch_t BR_JAL  = 3'd1;
  localparam branch_t BR_JALR = 3'd2;
  localparam branch_t BR_BEQ  = 3'd4;
  localparam branch_t BR_BNE  = 3'd5;
  localparam branch_t BR_BLT  = 3'd6; // also bltu
  localparam branch_t BR_BGE  = 3'd7; // also bgeu

  // stores reuse the signed codes
  localparam mem_op_t MEM_LB   = 3'd0;
  localparam mem_op_t MEM_LBU  = 3'd1;
  localparam mem_op_t MEM_LH   = 3'd2;
  localparam mem_op_t MEM_LHU  = 3'd3;
  localparam mem_op_t MEM_LW   = 3'd4;
  localparam mem_op_t MEM_LWU  = 3'd5;
  localparam mem_op_t MEM_LD   = 3'd6;
  localparam mem_op_t MEM_NONE = 3'd7;

  localparam b_src_t B_SRC_RS2  = 2'd0;
  localparam b_src_t B_SRC_IMM  = 2'd1;
  localparam b_src_t B_SRC_FOUR = 2'd2; // return address pc + 4

endpackage

//--- design/fetch_pkg.sv
// fetch path types: instruction address, instruction word and fetch FSM states
package fetch_pkg;

  typedef logic [31:0] inst_addr_t;
  typedef logic [31:0] inst_word_t;

  // sequential fetch step in bytes
  localparam inst_addr_t INST_BYTES = 32'd4;

  typedef enum logic [0:0] {
    IDLE     = 1'b0,
    WAIT_ACK = 1'b1  // read outstanding on the bus
  } fetch_state_t;

endpackage

//--- design/inst_fetch.sv
// instruction fetch: wishbone classic read master pushing sequential words into the queue
`timescale 1ns/1ps

module inst_fetch #(
  parameter fetch_pkg::inst_addr_t RESET_PC = 32'h8000_0000
) (
  input  logic                  i_clk,
  input  logic                  i_reset,
  output logic                  o_wb_cyc,
  output logic                  o_wb_stb,
  output fetch_pkg::inst_addr_t o_wb_adr,
  input  fetch_pkg::inst_word_t i_wb_dat,
  input  logic                  i_wb_ack,
  input  logic                  i_queue_full,
  output logic                  o_push,
  output fetch_pkg::inst_word_t o_push_inst,
  output fetch_pkg::inst_addr_t o_push_pc
);

  import fetch_pkg::*;

  fetch_state_t state;
  inst_addr_t   pc;
  logic         bus_done;

  assign bus_done = (state == WAIT_ACK) && i_wb_ack;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state <= IDLE;
      pc    <= RESET_PC;
    end else begin
      case (state)
        IDLE: begin
          if (!i_queue_full) state <= WAIT_ACK;
        end
        WAIT_ACK: begin
          if (i_wb_ack) begin
            state <= IDLE;
            pc    <= pc + INST_BYTES;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // cyc and stb rise and fall together
  assign o_wb_cyc = (state == WAIT_ACK);
  assign o_wb_stb = (state == WAIT_ACK);
  assign o_wb_adr = pc;

  assign o_push      = bus_done; // one cycle on the ack
  assign o_push_inst = i_wb_dat;
  assign o_push_pc   = pc;

  // slave acks only an active request
  a_ack_in_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
    i_wb_ack |-> o_wb_cyc && o_wb_stb);

  // address must hold until the slave acks
  a_adr_stable: assert property (@(posedge i_clk) disable iff (i_reset)
    o_wb_stb && !i_wb_ack |=> $stable(o_wb_adr));

endmodule

//--- design/inst_queue.sv
// instruction queue: synchronous circular FIFO of instruction word and address pairs
`timescale 1ns/1ps

module inst_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  logic                  i_push,
  input  fetch_pkg::inst_word_t i_push_inst,
  input  fetch_pkg::inst_addr_t i_push_pc,
  input  logic                  i_pop,
  output fetch_pkg::inst_word_t o_head_inst,
  output fetch_pkg::inst_addr_t o_head_pc,
  output logic                  o_empty,
  output logic                  o_full
);

  import fetch_pkg::*;

  localparam int AW = $clog2(QUEUE_DEPTH);

  inst_word_t    inst_mem [QUEUE_DEPTH];
  inst_addr_t    pc_mem   [QUEUE_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
      if (i_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({i_push, i_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_push) begin
      inst_mem[wr_ptr] <= i_push_inst;
      pc_mem[wr_ptr]   <= i_push_pc;
    end
  end

  assign o_head_inst = inst_mem[rd_ptr];
  assign o_head_pc   = pc_mem[rd_ptr];
  assign o_empty     = (count == '0);
  assign o_full      = (count == (AW+1)'(QUEUE_DEPTH));

  a_no_overflow: assert property (@(posedge i_clk) disable iff (i_reset)
    i_push |-> !o_full);

  a_no_underflow: assert property (@(posedge i_clk) disable iff (i_reset)
    i_pop |-> !o_empty);

endmodule

//--- design/inst_decode.sv
// instruction decode: pops the queue and registers one rv64im control record
`timescale 1ns/1ps

module inst_decode (
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  logic                  i_queue_empty,
  input  fetch_pkg::inst_word_t i_head_inst,
  input  fetch_pkg::inst_addr_t i_head_pc,
  output logic                  o_pop,
  input  logic                  i_dec_ready,
  output logic                  o_dec_valid,
  output fetch_pkg::inst_addr_t o_dec_pc,
  output rv_isa_pkg::xlen_t     o_dec_imm,
  output rv_isa_pkg::reg_idx_t  o_dec_rs1,
  output rv_isa_pkg::reg_idx_t  o_dec_rs2,
  output rv_isa_pkg::reg_idx_t  o_dec_rd,
  output rv_isa_pkg::alu_op_t   o_dec_alu_op,
  output logic                  o_dec_a_src,
  output rv_isa_pkg::b_src_t    o_dec_b_src,
  output rv_isa_pkg::branch_t   o_dec_branch,
  output rv_isa_pkg::mem_op_t   o_dec_mem_op,
  output logic                  o_dec_reg_wr,
  output logic                  o_dec_mem_to_reg,
  output logic                  o_dec_mem_wr,
  output logic                  o_dec_word_cut
);

  import rv_isa_pkg::*;

  opcode_t op;
  funct3_t f3;
  funct7_t f7;
  xlen_t   imm_i, imm_u, imm_s, imm_b, imm_j, imm;
  alu_op_t alu;
  branch_t br;
  mem_op_t mem;
  b_src_t  b_src;
  logic    t_r, t_i, t_u, t_s, t_b, t_j;
  logic    word_cut, a_src, reg_wr, mem_to_reg;

  assign op = i_head_inst[6:0];
  assign f3 = i_head_inst[14:12];
  assign f7 = i_head_inst[31:25];

  assign imm_i = {{52{i_head_inst[31]}}, i_head_inst[31:20]};
  assign imm_u = {{32{i_head_inst[31]}}, i_head_inst[31:12], 12'b0};
  assign imm_s = {{52{i_head_inst[31]}}, i_head_inst[31:25], i_head_inst[11:7]};
  assign imm_b = {{52{i_head_inst[31]}}, i_head_inst[7], i_head_inst[30:25],
                  i_head_inst[11:8], 1'b0};
  assign imm_j = {{44{i_head_inst[31]}}, i_head_inst[19:12], i_head_inst[20],
                  i_head_inst[30:21], 1'b0};

  always_comb begin
    alu      = ALU_INVALID;
    br       = BR_NONE;
    mem      = MEM_NONE;
    {t_r, t_i, t_u, t_s, t_b, t_j} = 6'b0;
    word_cut = 1'b0;
    case (op)
      OP_LUI: begin
        alu = ALU_COPY_IMM;
        t_u = 1'b1;
      end
      OP_AUIPC: begin
        alu = ALU_ADD;
        t_u = 1'b1;
      end
      OP_JAL: begin
        alu = ALU_ADD;
        br  = BR_JAL;
        t_j = 1'b1;
      end
      OP_JALR: begin
        if (f3 == 3'b000) begin
          alu = ALU_ADD;
          br  = BR_JALR;
          t_i = 1'b1;
        end
      end
      OP_BRANCH: begin
        case (f3)
          3'b000: begin alu = ALU_SLT;  br = BR_BEQ; end // compare via signed less
          3'b001: begin alu = ALU_SLT;  br = BR_BNE; end
          3'b100: begin alu = ALU_SLT;  br = BR_BLT; end
          3'b101: begin alu = ALU_SLT;  br = BR_BGE; end
          3'b110: begin alu = ALU_SLTU; br = BR_BLT; end
          3'b111: begin alu = ALU_SLTU; br = BR_BGE; end
          default: ;
        endcase
        t_b = (br != BR_NONE);
      end
      OP_LOAD: begin
        case (f3)
          3'b000:  mem = MEM_LB;
          3'b001:  mem = MEM_LH;
          3'b010:  mem = MEM_LW;
          3'b011:  mem = MEM_LD;
          3'b100:  mem = MEM_LBU;
          3'b101:  mem = MEM_LHU;
          3'b110:  mem = MEM_LWU;
          default: mem = MEM_NONE;
        endcase
        t_i = (mem != MEM_NONE);
        if (t_i) alu = ALU_ADD; // address calc
      end
      OP_STORE: begin
        case (f3)
          3'b000:  mem = MEM_LB;
          3'b001:  mem = MEM_LH;
          3'b010:  mem = MEM_LW;
          3'b011:  mem = MEM_LD;
          default: mem = MEM_NONE;
        endcase
        t_s = (mem != MEM_NONE);
        if (t_s) alu = ALU_ADD;
      end
      OP_IMM: begin
        case (f3)
          3'b000: alu = ALU_ADD;
          3'b010: alu = ALU_SLT;
          3'b011: alu = ALU_SLTU;
          3'b100: alu = ALU_XOR;
          3'b110: alu = ALU_OR;
          3'b111: alu = ALU_AND;
          3'b001: if (f7[6:1] == F7_BASE[6:1]) alu = ALU_SLL; // 6-bit shamt
          3'b101: begin
            if (f7[6:1] == F7_BASE[6:1]) alu = ALU_SRL;
            else if (f7[6:1] == F7_ALT[6:1]) alu = ALU_SRA;
          end
          default: ;
        endcase
        t_i = (alu != ALU_INVALID);
      end
      OP_IMM_32: begin
        case (f3)
          3'b000: alu = ALU_ADD;
          3'b001: if (f7 == F7_BASE) alu = ALU_SLL;
          3'b101: begin
            if (f7 == F7_BASE) alu = ALU_SRL;
            else if (f7 == F7_ALT) alu = ALU_SRA;
          end
          default: ;
        endcase
        t_i      = (alu != ALU_INVALID);
        word_cut = t_i;
      end
      OP_REG: begin
        case ({f7, f3})
          {F7_BASE, 3'b000}:   alu = ALU_ADD;
          {F7_BASE, 3'b001}:   alu = ALU_SLL;
          {F7_BASE, 3'b010}:   alu = ALU_SLT;
          {F7_BASE, 3'b011}:   alu = ALU_SLTU;
          {F7_BASE, 3'b100}:   alu = ALU_XOR;
          {F7_BASE, 3'b101}:   alu = ALU_SRL;
          {F7_BASE, 3'b110}:   alu = ALU_OR;
          {F7_BASE, 3'b111}:   alu = ALU_AND;
          {F7_ALT, 3'b000}:    alu = ALU_SUB;
          {F7_ALT, 3'b101}:    alu = ALU_SRA;
          {F7_MULDIV, 3'b000}: alu = ALU_MUL;
          {F7_MULDIV, 3'b100}: alu = ALU_DIV;
          {F7_MULDIV, 3'b101}: alu = ALU_DIVU;
          {F7_MULDIV, 3'b110}: alu = ALU_REM;
          {F7_MULDIV, 3'b111}: alu = ALU_REMU;
          default: ;
        endcase
        t_r = (alu != ALU_INVALID);
      end
      OP_REG_32: begin
        case ({f7, f3})
          {F7_BASE, 3'b000}:   alu = ALU_ADD;
          {F7_BASE, 3'b001}:   alu = ALU_SLL;
          {F7_BASE, 3'b101}:   alu = ALU_SRL;
          {F7_ALT, 3'b000}:    alu = ALU_SUB;
          {F7_ALT, 3'b101}:    alu = ALU_SRA;
          {F7_MULDIV, 3'b000}: alu = ALU_MUL;
          {F7_MULDIV, 3'b100}: alu = ALU_DIV;
          {F7_MULDIV, 3'b101}: alu = ALU_DIVU;
          {F7_MULDIV, 3'b110}: alu = ALU_REM;
          {F7_MULDIV, 3'b111}: alu = ALU_REMU;
          default: ;
        endcase
        t_r      = (alu != ALU_INVALID);
        word_cut = t_r;
      end
      OP_SYSTEM: begin
        if (f3 == 3'b000) begin
          alu = ALU_EBREAK;
          t_i = 1'b1;
        end else if (f3 == 3'b001) begin
          t_i = 1'b1; // csrrw, no alu op
        end
      end
      default: ;
    endcase
  end

  // r type carries no immediate, unknown words fall back to the i form
  always_comb begin
    if (t_u)      imm = imm_u;
    else if (t_s) imm = imm_s;
    else if (t_b) imm = imm_b;
    else if (t_j) imm = imm_j;
    else if (t_r) imm = '0;
    else          imm = imm_i;
  end

  assign a_src      = t_j || (br == BR_JALR) || (t_u && op == OP_AUIPC); // pc as operand a
  assign b_src      = (t_j || br == BR_JALR) ? B_SRC_FOUR :
                      (t_i || t_u || t_s)    ? B_SRC_IMM  : B_SRC_RS2;
  assign reg_wr     = t_r || t_i || t_u || t_j;
  assign mem_to_reg = t_i && (op == OP_LOAD);

  assign o_pop = !i_queue_empty && (!o_dec_valid || i_dec_ready);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_dec_valid <= 1'b0;
    end else if (o_pop) begin
      o_dec_valid <= 1'b1;
    end else if (i_dec_ready) begin
      o_dec_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_pop) begin
      o_dec_pc         <= i_head_pc;
      o_dec_imm        <= imm;
      o_dec_rs1        <= i_head_inst[19:15];
      o_dec_rs2        <= i_head_inst[24:20];
      o_dec_rd         <= i_head_inst[11:7];
      o_dec_alu_op     <= alu;
      o_dec_a_src      <= a_src;
      o_dec_b_src      <= b_src;
      o_dec_branch     <= br;
      o_dec_mem_op     <= mem;
      o_dec_reg_wr     <= reg_wr;
      o_dec_mem_to_reg <= mem_to_reg;
      o_dec_mem_wr     <= t_s;
      o_dec_word_cut   <= word_cut;
    end
  end

  a_hold_stalled: assert property (@(posedge i_clk) disable iff (i_reset)
    o_dec_valid && !i_dec_ready |=> o_dec_valid && $stable({o_dec_pc, o_dec_imm,
      o_dec_rs1, o_dec_rs2, o_dec_rd, o_dec_alu_op, o_dec_a_src, o_dec_b_src,
      o_dec_branch, o_dec_mem_op, o_dec_reg_wr, o_dec_mem_to_reg, o_dec_mem_wr,
      o_dec_word_cut}));

endmodule

//--- design/fetch_decode_top.sv
// fetch and decode front end: wishbone fetch, instruction queue and decode stage
`timescale 1ns/1ps

module fetch_decode_top #(
  parameter fetch_pkg::inst_addr_t RESET_PC    = 32'h8000_0000,
  parameter int                    QUEUE_DEPTH = 4
) (
  input  logic                  i_clk,
  input  logic                  i_reset,
  output logic                  o_wb_cyc,
  output logic                  o_wb_stb,
  output fetch_pkg::inst_addr_t o_wb_adr,
  input  fetch_pkg::inst_word_t i_wb_dat,
  input  logic                  i_wb_ack,
  input  logic                  i_dec_ready,
  output logic                  o_dec_valid,
  output fetch_pkg::inst_addr_t o_dec_pc,
  output rv_isa_pkg::xlen_t     o_dec_imm,
  output rv_isa_pkg::reg_idx_t  o_dec_rs1,
  output rv_isa_pkg::reg_idx_t  o_dec_rs2,
  output rv_isa_pkg::reg_idx_t  o_dec_rd,
  output rv_isa_pkg::alu_op_t   o_dec_alu_op,
  output logic                  o_dec_a_src,
  output rv_isa_pkg::b_src_t    o_dec_b_src,
  output rv_isa_pkg::branch_t   o_dec_branch,
  output rv_isa_pkg::mem_op_t   o_dec_mem_op,
  output logic                  o_dec_reg_wr,
  output logic                  o_dec_mem_to_reg,
  output logic                  o_dec_mem_wr,
  output logic                  o_dec_word_cut
);

  import fetch_pkg::*;

  logic       push, pop, queue_full, queue_empty;
  inst_word_t push_inst, head_inst;
  inst_addr_t push_pc, head_pc;

  inst_fetch #(
    .RESET_PC (RESET_PC)
  ) u_inst_fetch (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .o_wb_cyc     (o_wb_cyc),
    .o_wb_stb     (o_wb_stb),
    .o_wb_adr     (o_wb_adr),
    .i_wb_dat     (i_wb_dat),
    .i_wb_ack     (i_wb_ack),
    .i_queue_full (queue_full),
    .o_push       (push),
    .o_push_inst  (push_inst),
    .o_push_pc    (push_pc)
  );

  inst_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_inst_queue (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_push      (push),
    .i_push_inst (push_inst),
    .i_push_pc   (push_pc),
    .i_pop       (pop),
    .o_head_inst (head_inst),
    .o_head_pc   (head_pc),
    .o_empty     (queue_empty),
    .o_full      (queue_full)
  );

  inst_decode u_inst_decode (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_queue_empty    (queue_empty),
    .i_head_inst      (head_inst),
    .i_head_pc        (head_pc),
    .o_pop            (pop),
    .i_dec_ready      (i_dec_ready),
    .o_dec_valid      (o_dec_valid),
    .o_dec_pc         (o_dec_pc),
    .o_dec_imm        (o_dec_imm),
    .o_dec_rs1        (o_dec_rs1),
    .o_dec_rs2        (o_dec_rs2),
    .o_dec_rd         (o_dec_rd),
    .o_dec_alu_op     (o_dec_alu_op),
    .o_dec_a_src      (o_dec_a_src),
    .o_dec_b_src      (o_dec_b_src),
    .o_dec_branch     (o_dec_branch),
    .o_dec_mem_op     (o_dec_mem_op),
    .o_dec_reg_wr     (o_dec_reg_wr),
    .o_dec_mem_to_reg (o_dec_mem_to_reg),
    .o_dec_mem_wr     (o_dec_mem_wr),
    .o_dec_word_cut   (o_dec_word_cut)
  );

endmodule

//--- tb/tb_fetch_decode.sv
// fetch and decode testbench: wishbone instruction memory with wait states and record checks
`timescale 1ns/1ps

module tb_fetch_decode;

  import rv_isa_pkg::*;
  import fetch_pkg::*;

  localparam inst_addr_t RESET_PC     = 32'h8000_0000;
  localparam int         N_INST       = 20;
  localparam int         N_COLS       = 11; // fields per stim line
  localparam int         RESET_CYCLES = 16;
  localparam int         MAX_CYCLES   = RESET_CYCLES + 12 * N_INST + 100;
  localparam inst_word_t NOP_WORD     = 32'h0000_0013;
  localparam int         STALL_START  = 20;
  localparam int         STALL_END    = 60;

  logic       clk;
  logic       reset;
  logic       wb_cyc, wb_stb, wb_ack;
  inst_addr_t wb_adr;
  inst_word_t wb_dat;
  logic       dec_ready, dec_valid;
  inst_addr_t dec_pc;
  xlen_t      dec_imm;
  reg_idx_t   dec_rs1, dec_rs2, dec_rd;
  alu_op_t    dec_alu_op;
  logic       dec_a_src;
  b_src_t     dec_b_src;
  branch_t    dec_branch;
  mem_op_t    dec_mem_op;
  logic       dec_reg_wr, dec_mem_to_reg, dec_mem_wr, dec_word_cut;

  logic [63:0] stim [N_INST*N_COLS];
  integer      seed = 9222;
  int          cycles;
  int          rec_idx;
  int          wait_cnt;
  logic        first_req;

  fetch_decode_top #(
    .RESET_PC    (RESET_PC),
    .QUEUE_DEPTH (4)
  ) u_fetch_decode_top (
    .i_clk (clk), .i_reset (reset),
    .o_wb_cyc (wb_cyc), .o_wb_stb (wb_stb), .o_wb_adr (wb_adr),
    .i_wb_dat (wb_dat), .i_wb_ack (wb_ack),
    .i_dec_ready (dec_ready), .o_dec_valid (dec_valid),
    .o_dec_pc (dec_pc), .o_dec_imm (dec_imm),
    .o_dec_rs1 (dec_rs1), .o_dec_rs2 (dec_rs2), .o_dec_rd (dec_rd),
    .o_dec_alu_op (dec_alu_op), .o_dec_a_src (dec_a_src), .o_dec_b_src (dec_b_src),
    .o_dec_branch (dec_branch), .o_dec_mem_op (dec_mem_op),
    .o_dec_reg_wr (dec_reg_wr), .o_dec_mem_to_reg (dec_mem_to_reg),
    .o_dec_mem_wr (dec_mem_wr), .o_dec_word_cut (dec_word_cut)
  );

  always #50 clk = ~clk;

  task automatic report_fail(input string name, input logic [63:0] got, input logic [63:0] exp);
    $display("error: time %0t: %s is %h, expected %h", $time, name, got, exp);
    $display("TB FAILED");
    $fatal(1, "decode record mismatch");
  endtask

  task automatic check_imm(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) report_fail(name, got, exp);
  endtask

  task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) report_fail(name, got, exp);
  endtask

  task automatic check_alu(input string name, input alu_op_t got, input alu_op_t exp);
    if (got !== exp) report_fail(name, got, exp);
  endtask

  task automatic check_branch(input string name, input branch_t got, input branch_t exp);
    if (got !== exp) report_fail(name, got, exp);
  endtask

  task automatic check_mem(input string name, input mem_op_t got, input mem_op_t exp);
    if (got !== exp) report_fail(name, got, exp);
  endtask

  task automatic check_b_src(input string name, input b_src_t got, input b_src_t exp);
    if (got !== exp) report_fail(name, got, exp);
  endtask

  task automatic check_pc(input string name, input inst_addr_t got, input inst_addr_t exp);
    if (got !== exp) report_fail(name, got, exp);
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) report_fail(name, got, exp);
  endtask

  // instruction memory answering after 0 to 3 wait cycles
  task automatic serve_bus();
    inst_addr_t offs;
    wb_ack = 1'b0;
    if (wb_cyc && wb_stb) begin
      if (first_req) begin
        check_pc("o_wb_adr", wb_adr, RESET_PC);
        first_req = 1'b0;
      end
      if (wait_cnt == 0) begin
        offs     = wb_adr - RESET_PC;
        wb_dat   = (offs < N_INST * 4) ? stim[(offs >> 2) * N_COLS][31:0] : NOP_WORD;
        wb_ack   = 1'b1;
        wait_cnt = $unsigned($random(seed)) % 4;
      end else begin
        wait_cnt = wait_cnt - 1;
      end
    end
  endtask

  task automatic check_record(input int idx);
    int         base;
    inst_word_t inst;
    base = idx * N_COLS;
    inst = stim[base][31:0];
    check_pc("o_dec_pc", dec_pc, RESET_PC + inst_addr_t'(4 * idx)); // program order
    check_reg("o_dec_rs1", dec_rs1, inst[19:15]);
    check_reg("o_dec_rs2", dec_rs2, inst[24:20]);
    check_reg("o_dec_rd", dec_rd, inst[11:7]);
    check_imm("o_dec_imm", dec_imm, stim[base+1]);
    check_alu("o_dec_alu_op", dec_alu_op, alu_op_t'(stim[base+2]));
    check_b_src("o_dec_b_src", dec_b_src, b_src_t'(stim[base+3]));
    check_flag("o_dec_a_src", dec_a_src, stim[base+4][0]);
    check_branch("o_dec_branch", dec_branch, branch_t'(stim[base+5]));
    check_mem("o_dec_mem_op", dec_mem_op, mem_op_t'(stim[base+6]));
    check_flag("o_dec_reg_wr", dec_reg_wr, stim[base+7][0]);
    check_flag("o_dec_mem_to_reg", dec_mem_to_reg, stim[base+8][0]);
    check_flag("o_dec_mem_wr", dec_mem_wr, stim[base+9][0]);
    check_flag("o_dec_word_cut", dec_word_cut, stim[base+10][0]);
  endtask

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    wb_ack    = 1'b0;
    wb_dat    = '0;
    dec_ready = 1'b0;
    cycles    = 0;
    rec_idx   = 0;
    first_req = 1'b1;
    wait_cnt  = $unsigned($random(seed)) % 4;
    $readmemh("tb/fetch_decode_stim.txt", stim);
    if ($isunknown(stim[N_INST*N_COLS-1])) begin
      $display("stim file is missing or has fewer lines than expected");
      $display("TB FAILED");
      $fatal(1, "no stimulus");
    end
    repeat (RESET_CYCLES) @(negedge clk);
    check_flag("o_dec_valid", dec_valid, 1'b0);
    check_flag("o_wb_cyc", wb_cyc, 1'b0);
    check_flag("o_wb_stb", wb_stb, 1'b0);
    reset = 1'b0;
    while (rec_idx < N_INST && cycles < MAX_CYCLES) begin
      @(negedge clk);
      cycles = cycles + 1;
      serve_bus();
      // long stall fills the queue and holds fetch off
      if (cycles > STALL_START && cycles <= STALL_END) begin
        dec_ready = 1'b0;
      end else begin
        dec_ready = ($random(seed) & 1) != 0;
      end
      if (dec_valid && dec_ready) begin // taken on the next rising edge
        check_record(rec_idx);
        rec_idx = rec_idx + 1;
      end
    end
    if (rec_idx == N_INST) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("timeout, only %0d of %0d records arrived", rec_idx, N_INST);
      $display("TB FAILED");
      $fatal(1, "timeout");
    end
  end

endmodule

//--- tb/fetch_decode_stim.txt
// inst imm alu_op b_src a_src branch mem_op reg_wr mem_to_reg mem_wr word_cut
// addi lui auipc add sub mul divu addw addiw srai ld lbu sw bne bgeu jal jalr ebreak csrrw bad
FFF08113 FFFFFFFFFFFFFFFF 00 1 0 0 7 1 0 0 0
800001B7 FFFFFFFF80000000 0F 1 0 0 7 1 0 0 0
12345217 0000000012345000 00 1 1 0 7 1 0 0 0
007302B3 0000000000000000 00 0 0 0 7 1 0 0 0
40A48433 0000000000000000 01 0 0 0 7 1 0 0 0
03078733 0000000000000000 0A 0 0 0 7 1 0 0 0
033958B3 0000000000000000 0C 0 0 0 7 1 0 0 0
016A8A3B 0000000000000000 00 0 0 0 7 1 0 0 1
FF0C0B9B FFFFFFFFFFFFFFF0 00 1 0 0 7 1 0 0 1
43FD5C93 000000000000043F 09 1 0 0 7 1 0 0 0
FF8E3D83 FFFFFFFFFFFFFFF8 00 1 0 0 6 1 1 0 0
00414083 0000000000000004 00 1 0 0 1 1 1 0 0
FE322E23 FFFFFFFFFFFFFFFC 00 1 0 0 4 0 0 1 0
FE629CE3 FFFFFFFFFFFFFFF8 02 0 0 5 7 0 0 0 0
0083F863 0000000000000010 03 0 0 7 7 0 0 0 0
001000EF 0000000000000800 00 2 1 1 7 1 0 0 0
00008067 0000000000000000 00 2 1 2 7 1 0 0 0
00100073 0000000000000001 1E 1 0 0 7 1 0 0 0
340312F3 0000000000000340 1F 1 0 0 7 1 0 0 0
FFFFFFFF FFFFFFFFFFFFFFFF 1F 0 0 0 7 0 0 0 0

//--- vlog.f
design/rv_isa_pkg.sv
design/fetch_pkg.sv
design/inst_fetch.sv
design/inst_queue.sv
design/inst_decode.sv
design/fetch_decode_top.sv
tb/tb_fetch_decode.sv
